// ==== imgConv.f ====
verilog/convPkg.sv
verilog/ctrlPkg.sv
verilog/convBus.sv
verilog/controlBlock.sv
verilog/imageStore.sv
verilog/convSequencer.sv
verilog/convEngine.sv
verilog/imgConvTop.sv
testbench/imgConvTb_assertions.sv
testbench/imgConvTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the image convolution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module imgConvTb -f imgConv.f -o imgConvSim

output=$(./obj_dir/imgConvSim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

// ==== testbench/imgConvTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module imgConvTb
  import ctrlPkg::*;
();

  localparam int    CLK_HALF     = 2;
  localparam int    DRIVE_DELAY  = 1;
  localparam int    SEED         = 63;
  localparam int    PAT_WORDS    = 256;
  localparam int    PULSE_LIMIT  = 12;
  localparam string PATTERN_FILE = "testbench/imgConv_patterns.txt";

  logic        clk;
  logic        rst;
  logic [23:0] gpioData;
  logic [2:0]  gpioCtrl;
  logic        gpioValid;
  logic [7:0]  mcuData;
  logic        mcuValid;
  logic        runFlag;
  logic        eopFlag;

  logic [23:0] patMem [PAT_WORDS];
  logic        patternsLoaded = 1'b0;
  int          watchCycles = 0;
  int          checkCount = 0;
  int          errorCount = 0;

  imgConvTop #(.IMG_DEPTH(64)) dut0 (
    .i_CLK       (clk),
    .i_rst       (rst),
    .i_gpioData  (gpioData),
    .i_gpioCtrl  (gpioCtrl),
    .i_gpioValid (gpioValid),
    .o_mcuData   (mcuData),
    .o_mcuValid  (mcuValid),
    .o_run       (runFlag),
    .o_eop       (eopFlag)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  function automatic int randomHold(input logic longPulse);
    if (longPulse) begin
      return 5 + int'($urandom % 4);
    end
    return 1 + int'($urandom % 4);
  endfunction

  task automatic checkValue(input string name, input logic [23:0] expected,
                            input logic [23:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic checkEvent(input logic seen, input string what);
    checkCount++;
    if (!seen) begin
      errorCount++;
      $display("Error: %s", what);
    end
  endtask

  // Valid rises once per command and drops for at least one edge
  task automatic sendCommand(input gpioOpT op, input logic [23:0] data, input int holdCycles);
    @(posedge clk);
    #DRIVE_DELAY;
    gpioCtrl  = op;
    gpioData  = data;
    gpioValid = 1'b1;
    repeat (holdCycles) @(posedge clk);
    #DRIVE_DELAY;
    gpioValid = 1'b0;
    @(posedge clk);
  endtask

  task automatic waitRunRise(output logic seen);
    seen = 1'b0;
    for (int i = 0; i < PULSE_LIMIT && !seen; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (runFlag) begin
        seen = 1'b1;
      end
    end
  endtask

  task automatic waitEop(input int limit, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (eopFlag) begin
        seen = 1'b1;
      end
    end
  endtask

  // Grabs the readback pulse and the data valid with it
  task automatic catchReadData(output logic seen, output logic [7:0] data);
    seen = 1'b0;
    data = '0;
    for (int i = 0; i < PULSE_LIMIT && !seen; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (mcuValid) begin
        seen = 1'b1;
        data = mcuData;
      end
    end
  endtask

  task automatic requestResult(input int hold, output logic seen, output logic [7:0] data);
    fork
      sendCommand(OP_REQUEST, 24'h0, hold);
      catchReadData(seen, data);
    join
  endtask

  // No readback may leave the block during a run
  always @(negedge clk) begin
    if (runFlag && mcuValid) begin
      errorCount++;
      $display("Error: o_mcuValid pulsed while o_run was high");
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////

  initial begin
    wait (patternsLoaded);
    repeat (watchCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int          ptr;
    int          patIdx;
    int          flags;
    int          len;
    int          items;
    logic        intrude;
    logic        longPulse;
    logic        seen;
    logic [7:0]  readData;

    void'($urandom(SEED));
    rst       = 1'b1;
    gpioValid = 1'b0;
    gpioCtrl  = OP_KERNEL;
    gpioData  = '0;

    $readmemh(PATTERN_FILE, patMem);

    // Budget from every column, request and setup command in the file
    items = 0;
    ptr   = 0;
    while (ptr + 1 < PAT_WORDS && patMem[ptr+1] != 0) begin
      len   = int'(patMem[ptr+1]);
      items = items + 2 * len + 5;
      ptr   = ptr + 2 * len + 3;
    end
    watchCycles    = items * 40 + 200;
    patternsLoaded = 1'b1;

    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // Idle outputs before any command
    @(posedge clk);
    #DRIVE_DELAY;
    checkValue("o_run", 24'h0, 24'(runFlag));
    checkValue("o_eop", 24'h0, 24'(eopFlag));
    checkValue("o_mcuValid", 24'h0, 24'(mcuValid));

    ptr    = 0;
    patIdx = 0;
    while (ptr + 1 < PAT_WORDS && patMem[ptr+1] != 0) begin
      flags     = int'(patMem[ptr]);
      len       = int'(patMem[ptr+1]);
      intrude   = (flags & 1) != 0;
      longPulse = (flags & 2) != 0;

      // Oldest kernel row first
      for (int r = 0; r < 3; r++) begin
        sendCommand(OP_KERNEL, patMem[ptr+2+r], randomHold(longPulse));
      end
      sendCommand(OP_SIZE, 24'(len), randomHold(longPulse));
      for (int c = 0; c < len; c++) begin
        sendCommand(OP_IMAGE, patMem[ptr+5+c], randomHold(longPulse));
      end

      // Short run pulse leaves time for commands inside the run
      fork
        sendCommand(OP_RUN, 24'h0, intrude ? 1 : randomHold(longPulse));
        waitRunRise(seen);
      join
      checkEvent(seen, $sformatf("o_run did not rise after OP_RUN in pattern %0d", patIdx));

      if (intrude) begin
        @(negedge clk);
        checkEvent(runFlag, "run ended before the OP_IMAGE sent during it");
        sendCommand(OP_IMAGE, 24'hA5A5A5, 1);
        @(negedge clk);
        checkEvent(runFlag, "run ended before the OP_REQUEST sent during it");
        sendCommand(OP_REQUEST, 24'h0, 1);
      end

      waitEop(len + 10, seen);
      checkEvent(seen, $sformatf("o_eop did not rise within %0d cycles in pattern %0d",
                                 len + 10, patIdx));
      checkValue("o_run", 24'h0, 24'(runFlag));

      // Results come back in index order
      for (int k = 0; k < len - 2; k++) begin
        requestResult(randomHold(longPulse), seen, readData);
        checkEvent(seen, $sformatf("no o_mcuValid pulse for request %0d of pattern %0d",
                                   k, patIdx));
        if (seen) begin
          checkValue($sformatf("o_mcuData (pattern %0d, result %0d)", patIdx, k),
                     patMem[ptr+5+len+k], 24'(readData));
        end
      end

      ptr    = ptr + 2 * len + 3;
      patIdx = patIdx + 1;
    end

    checkEvent(patIdx != 0, "no test patterns were read from the pattern file");

    repeat (4) @(posedge clk);
    $display("Patterns: %0d, checks: %0d, errors: %0d", patIdx, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/imgConvTb_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

// Protocol rules of the command decoder
module controlBlockAsserts (
  input wire logic i_CLK,
  input wire logic i_rst,
  input wire logic i_run,
  input wire logic i_eop,
  input wire logic i_mcuValid,
  input wire logic i_colWrEn
);

  // Busy and finished flags are exclusive
  runEopExclusive: assert property (
    @(posedge i_CLK) disable iff (i_rst) !(i_run && i_eop)
  ) else $error("o_run and o_eop are high at the same time");

  // Result store belongs to the sequencer during a run
  noReadDuringRun: assert property (
    @(posedge i_CLK) disable iff (i_rst) !(i_mcuValid && i_run)
  ) else $error("o_mcuValid pulsed while o_run was high");

  // Column memory frozen while the run streams it
  noWriteDuringRun: assert property (
    @(posedge i_CLK) disable iff (i_rst) !(i_colWrEn && i_run)
  ) else $error("column write happened while o_run was high");

endmodule

bind controlBlock controlBlockAsserts asserts0 (
  .i_CLK      (i_CLK),
  .i_rst      (i_rst),
  .i_run      (o_run),
  .i_eop      (o_eop),
  .i_mcuValid (o_mcuValid),
  .i_colWrEn  (load.colWrEn)
);

`default_nettype wire

// ==== testbench/imgConv_patterns.txt ====
// Record: flags and length, three kernel rows (top first), the columns, the expected results
// Flags bit0 sends commands during the run, bit1 holds valid high for long pulses; 0 0 ends the file
0 6
0100FF 0200FE 0100FF
501020 000000 100804 FFFFFF 020103 004000
6C 00 1D FF

1 5
000100 010201 00FF00
050A00 200310 014000 080230 001100
60 86 2D

2 4
010101 000000 01FF01
115502 226604 337708 448810
6C A5

0 0

// ==== verilog/controlBlock.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlBlock
  import convPkg::*, ctrlPkg::*;
#(
  parameter int IMG_DEPTH = 64
) (
  input  logic      i_CLK,
  input  logic      i_rst,
  input  columnT    i_gpioData,
  input  gpioOpT    i_gpioCtrl,
  input  logic      i_gpioValid,
  input  logic      i_done,
  output logic      o_kerWrEn,
  output kernelRowT o_kerRow,
  output logic      o_start,
  output lenT       o_imgLength,
  output resultT    o_mcuData,
  output logic      o_mcuValid,
  output logic      o_run,
  output logic      o_eop,
  loadIf.ctrl       load
);

  localparam int ADDR_W = $clog2(IMG_DEPTH);
  // Largest length the store and lenT both hold
  localparam lenT LEN_MAX = (IMG_DEPTH > 1023) ? lenT'(1023) : lenT'(IMG_DEPTH);
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(IMG_DEPTH - 1);

  logic              validPrev;
  logic              cmdStrobe;
  logic              cmdValid;
  gpioOpT            cmdOp;
  columnT            cmdData;
  logic [ADDR_W-1:0] colWrPtr;
  logic [ADDR_W-1:0] resRdPtr;
  lenT               imgLength;
  logic              runR;
  logic              eopR;
  logic              rdPending;

  ////////////////////////////////////////////////////////////////////
  // Command capture
  ////////////////////////////////////////////////////////////////////

  // Rising edge of the valid line
  assign cmdStrobe = i_gpioValid && !validPrev;

  // Opcode and data held for the decode cycle
  always_ff @(posedge i_CLK) begin
    if (cmdStrobe) begin
      cmdOp   <= i_gpioCtrl;
      cmdData <= i_gpioData;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Decoded strobes
  ////////////////////////////////////////////////////////////////////

  assign o_kerWrEn = cmdValid && (cmdOp == OP_KERNEL);
  assign o_kerRow  = cmdData;
  assign o_start   = cmdValid && (cmdOp == OP_RUN);

  // Column write at the write pointer
  assign load.colWrEn   = cmdValid && (cmdOp == OP_IMAGE);
  assign load.colWrAddr = colWrPtr;
  assign load.colWrData = cmdData;

  // Result read at the read pointer
  assign load.resRdEn   = cmdValid && (cmdOp == OP_REQUEST);
  assign load.resRdAddr = resRdPtr;

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      validPrev <= 1'b0;
      cmdValid  <= 1'b0;
      colWrPtr  <= '0;
      resRdPtr  <= '0;
      imgLength <= '0;
      runR      <= 1'b0;
      eopR      <= 1'b0;
      rdPending <= 1'b0;
    end else begin
      validPrev <= i_gpioValid;
      // Commands dropped while the run owns the store
      cmdValid  <= cmdStrobe && !runR;
      rdPending <= load.resRdEn;

      if (cmdValid) begin
        case (cmdOp)
          OP_SIZE: begin
            imgLength <= (cmdData[9:0] > LEN_MAX) ? LEN_MAX : cmdData[9:0];
            colWrPtr  <= '0;
            resRdPtr  <= '0;
          end
          OP_IMAGE: begin
            if (colWrPtr != LAST_ADDR) begin
              colWrPtr <= colWrPtr + 1'b1;
            end
          end
          OP_REQUEST: begin
            if (resRdPtr != LAST_ADDR) begin
              resRdPtr <= resRdPtr + 1'b1;
            end
          end
          default: ;
        endcase
      end

      // Run flag hands the store to the sequencer and back
      if (runR) begin
        if (i_done) begin
          runR <= 1'b0;
          eopR <= 1'b1;
        end
      end else if (cmdStrobe && (i_gpioCtrl == OP_RUN)) begin
        runR <= 1'b1;
        eopR <= 1'b0;
      end else if (load.colWrEn) begin
        // New image data, old results stale
        eopR <= 1'b0;
      end
    end
  end

  assign o_imgLength = imgLength;
  assign o_run       = runR;
  assign o_eop       = eopR;

  // Store data lands one cycle after the read pulse
  assign o_mcuData  = load.resRdData;
  assign o_mcuValid = rdPending;

endmodule

`default_nettype wire

// ==== verilog/convBus.sv ====
`timescale 1ns/1ns
`default_nettype none

// Load and readback path, control block to store
interface loadIf
  import convPkg::*;
#(
  parameter int ADDR_W = 6
) ();
  logic              colWrEn;
  logic [ADDR_W-1:0] colWrAddr;
  columnT            colWrData;
  logic              resRdEn;
  logic [ADDR_W-1:0] resRdAddr;
  // Valid one cycle after resRdEn
  resultT            resRdData;

  modport ctrl  (output colWrEn, colWrAddr, colWrData, resRdEn, resRdAddr,
                 input resRdData);
  modport store (input colWrEn, colWrAddr, colWrData, resRdEn, resRdAddr,
                 output resRdData);
endinterface

// Run path, sequencer to store
interface runIf
  import convPkg::*;
#(
  parameter int ADDR_W = 6
) ();
  logic [ADDR_W-1:0] colRdAddr;
  // Column one cycle after its address
  columnT            colRdData;
  logic              resWrEn;
  logic [ADDR_W-1:0] resWrAddr;
  resultT            resWrData;

  modport seq   (output colRdAddr, resWrEn, resWrAddr, resWrData, input colRdData);
  modport store (input colRdAddr, resWrEn, resWrAddr, resWrData, output colRdData);
endinterface

// Column stream into the engine and results back
interface engineIf
  import convPkg::*;
();
  logic   colValid;
  // Marks first column of a run
  logic   colFirst;
  columnT col;
  logic   resValid;
  resultT res;

  modport src (output colValid, colFirst, col, input resValid, res);
  modport eng (input colValid, colFirst, col, output resValid, res);
endinterface

`default_nettype wire

// ==== verilog/convEngine.sv ====
`timescale 1ns/1ns
`default_nettype none

module convEngine
  import convPkg::*;
(
  input  logic      i_CLK,
  input  logic      i_rst,
  input  logic      i_kerWrEn,
  input  kernelRowT i_kerRow,
  engineIf.eng      eng
);

  kernelRowT          kerRows [3];
  columnT             winPrev [2];
  columnT             winCols [3];
  logic [1:0]         fillCnt;
  logic               winFull;
  logic signed [16:0] prod [3][3];
  logic               prodValid;
  accT                accSum;
  resultT             resR;
  logic               resValidR;

  // Pixel of image row r, top row in the high byte
  function automatic pixelT pixelAt(columnT c, int r);
    return c[23 - 8*r -: 8];
  endfunction

  // Tap t of a kernel row, leftmost in the high byte
  function automatic coefT coefAt(kernelRowT k, int t);
    return coefT'(k[23 - 8*t -: 8]);
  endfunction

  // Kernel shift register, oldest row on top
  always_ff @(posedge i_CLK) begin
    if (i_kerWrEn) begin
      kerRows[0] <= kerRows[1];
      kerRows[1] <= kerRows[2];
      kerRows[2] <= i_kerRow;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Column window
  ////////////////////////////////////////////////////////////////////

  // Two stored columns plus the incoming one
  assign winCols[0] = winPrev[0];
  assign winCols[1] = winPrev[1];
  assign winCols[2] = eng.col;
  assign winFull    = eng.colValid && !eng.colFirst && (fillCnt == 2'd2);

  always_ff @(posedge i_CLK) begin
    if (eng.colValid) begin
      winPrev[0] <= winPrev[1];
      winPrev[1] <= eng.col;
    end
  end

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      fillCnt <= '0;
    end else if (eng.colValid) begin
      if (eng.colFirst) begin
        fillCnt <= 2'd1;
      end else if (fillCnt != 2'd2) begin
        fillCnt <= fillCnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Multiply and accumulate pipeline
  ////////////////////////////////////////////////////////////////////

  // Stage one, nine signed products
  always_ff @(posedge i_CLK) begin
    for (int r = 0; r < 3; r++) begin
      for (int t = 0; t < 3; t++) begin
        prod[r][t] <= $signed({1'b0, pixelAt(winCols[t], r)}) * coefAt(kerRows[r], t);
      end
    end
  end

  // Adder tree feeding stage two
  always_comb begin
    accSum = '0;
    for (int r = 0; r < 3; r++) begin
      for (int t = 0; t < 3; t++) begin
        accSum = accSum + prod[r][t];
      end
    end
  end

  // Stage two, clamp to 0..255
  always_ff @(posedge i_CLK) begin
    if (accSum < 0) begin
      resR <= '0;
    end else if (accSum > 255) begin
      resR <= 8'hFF;
    end else begin
      resR <= accSum[7:0];
    end
  end

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      prodValid <= 1'b0;
      resValidR <= 1'b0;
    end else begin
      prodValid <= winFull;
      resValidR <= prodValid;
    end
  end

  assign eng.res      = resR;
  assign eng.resValid = resValidR;

endmodule

`default_nettype wire

// ==== verilog/convPkg.sv ====
`default_nettype none

// Data types shared by the datapath blocks
package convPkg;

  ////////////////////////////////////////////////////////////////////
  // Pixel and column types
  ////////////////////////////////////////////////////////////////////

  // Unsigned image pixel
  typedef logic [7:0] pixelT;

  // Three pixels of one column, top row in the high byte
  typedef logic [23:0] columnT;

  ////////////////////////////////////////////////////////////////////
  // Kernel and arithmetic types
  ////////////////////////////////////////////////////////////////////

  // Signed kernel tap
  typedef logic signed [7:0] coefT;

  // One kernel row, leftmost tap in the high byte
  typedef logic [23:0] kernelRowT;

  // Image length in columns
  typedef logic [9:0] lenT;

  // Nine products of 17 bits fit with room to spare
  typedef logic signed [20:0] accT;

  // Output pixel after clamping
  typedef logic [7:0] resultT;

endpackage

`default_nettype wire

// ==== verilog/convSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module convSequencer
  import convPkg::*, ctrlPkg::*;
#(
  parameter int IMG_DEPTH = 64
) (
  input  logic  i_CLK,
  input  logic  i_rst,
  input  logic  i_start,
  input  lenT   i_imgLength,
  output logic  o_done,
  runIf.seq     run,
  engineIf.src  eng
);

  localparam int ADDR_W = $clog2(IMG_DEPTH);

  seqStateT          state;
  logic [ADDR_W-1:0] rdAddr;
  logic              colValidR;
  logic              colFirstR;
  lenT               resCnt;
  logic              lastAddr;
  logic              lastRes;
  logic              running;

  // Final column address of the image
  assign lastAddr = (lenT'(rdAddr) == i_imgLength - lenT'(1));
  // Length minus two results per run
  assign lastRes  = eng.resValid && (resCnt == i_imgLength - lenT'(3));
  assign running  = (state == SEQ_STREAM) || (state == SEQ_DRAIN);

  ////////////////////////////////////////////////////////////////////
  // Run FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      state     <= SEQ_IDLE;
      rdAddr    <= '0;
      colValidR <= 1'b0;
      colFirstR <= 1'b0;
      resCnt    <= '0;
    end else begin
      // Column data follows its address by one cycle
      colValidR <= (state == SEQ_STREAM);
      colFirstR <= (state == SEQ_STREAM) && (rdAddr == '0);

      case (state)
        SEQ_IDLE: begin
          rdAddr <= '0;
          resCnt <= '0;
          if (i_start) begin
            // Too short for a single 3-wide window
            state <= (i_imgLength < lenT'(3)) ? SEQ_DONE : SEQ_STREAM;
          end
        end
        SEQ_STREAM: begin
          if (lastAddr) begin
            state <= SEQ_DRAIN;
          end else begin
            rdAddr <= rdAddr + 1'b1;
          end
        end
        SEQ_DRAIN: begin
          // Pipeline still has columns in flight
          if (lastRes) begin
            state <= SEQ_DONE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase

      // One write slot per engine result
      if (running && eng.resValid) begin
        resCnt <= resCnt + 1'b1;
      end
    end
  end

  // Column stream
  assign run.colRdAddr = rdAddr;
  assign eng.colValid  = colValidR;
  assign eng.colFirst  = colFirstR;
  assign eng.col       = run.colRdData;

  // Result writeback
  assign run.resWrEn   = running && eng.resValid;
  assign run.resWrAddr = resCnt[ADDR_W-1:0];
  assign run.resWrData = eng.res;

  assign o_done = (state == SEQ_DONE);

endmodule

`default_nettype wire

// ==== verilog/ctrlPkg.sv ====
`default_nettype none

// Control encodings for the command decoder and sequencer
package ctrlPkg;

  ////////////////////////////////////////////////////////////////////
  // GPIO command opcodes
  ////////////////////////////////////////////////////////////////////

  // Codes 5 to 7 are not decoded
  typedef enum logic [2:0] {
    OP_KERNEL  = 3'd0,
    OP_SIZE    = 3'd1,
    OP_IMAGE   = 3'd2,
    OP_REQUEST = 3'd3,
    OP_RUN     = 3'd4
  } gpioOpT;

  ////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_STREAM,
    SEQ_DRAIN,
    SEQ_DONE
  } seqStateT;

endpackage

`default_nettype wire

// ==== verilog/imageStore.sv ====
`timescale 1ns/1ns
`default_nettype none

module imageStore
  import convPkg::*;
#(
  parameter int IMG_DEPTH = 64
) (
  input  logic i_CLK,
  loadIf.store load,
  runIf.store  run
);

  columnT colMem [IMG_DEPTH];
  resultT resMem [IMG_DEPTH];

  ////////////////////////////////////////////////////////////////////
  // Column memory
  ////////////////////////////////////////////////////////////////////

  // Written by the MCU load path
  always_ff @(posedge i_CLK) begin
    if (load.colWrEn) begin
      colMem[load.colWrAddr] <= load.colWrData;
    end
  end

  // Sequencer read, free running
  always_ff @(posedge i_CLK) begin
    run.colRdData <= colMem[run.colRdAddr];
  end

  ////////////////////////////////////////////////////////////////////
  // Result memory
  ////////////////////////////////////////////////////////////////////

  // Filled by the sequencer during a run
  always_ff @(posedge i_CLK) begin
    if (run.resWrEn) begin
      resMem[run.resWrAddr] <= run.resWrData;
    end
  end

  // MCU readback, holds between requests
  always_ff @(posedge i_CLK) begin
    if (load.resRdEn) begin
      load.resRdData <= resMem[load.resRdAddr];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/imgConvTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module imgConvTop
  import convPkg::*, ctrlPkg::*;
#(
  parameter int IMG_DEPTH = 64
) (
  input  logic        i_CLK,
  input  logic        i_rst,
  input  logic [23:0] i_gpioData,
  input  logic [2:0]  i_gpioCtrl,
  input  logic        i_gpioValid,
  output logic [7:0]  o_mcuData,
  output logic        o_mcuValid,
  output logic        o_run,
  output logic        o_eop
);

  localparam int ADDR_W = $clog2(IMG_DEPTH);

  logic      kerWrEn;
  kernelRowT kerRow;
  logic      start;
  lenT       imgLength;
  logic      done;

  // Internal buses
  loadIf #(.ADDR_W(ADDR_W)) loadBus ();
  runIf  #(.ADDR_W(ADDR_W)) runBus ();
  engineIf                  engBus ();

  // MCU command decoder
  controlBlock #(.IMG_DEPTH(IMG_DEPTH)) ctrl0 (
    .i_CLK       (i_CLK),
    .i_rst       (i_rst),
    .i_gpioData  (i_gpioData),
    .i_gpioCtrl  (gpioOpT'(i_gpioCtrl)),
    .i_gpioValid (i_gpioValid),
    .i_done      (done),
    .o_kerWrEn   (kerWrEn),
    .o_kerRow    (kerRow),
    .o_start     (start),
    .o_imgLength (imgLength),
    .o_mcuData   (o_mcuData),
    .o_mcuValid  (o_mcuValid),
    .o_run       (o_run),
    .o_eop       (o_eop),
    .load        (loadBus.ctrl)
  );

  imageStore #(.IMG_DEPTH(IMG_DEPTH)) store0 (
    .i_CLK (i_CLK),
    .load  (loadBus.store),
    .run   (runBus.store)
  );

  convSequencer #(.IMG_DEPTH(IMG_DEPTH)) seq0 (
    .i_CLK       (i_CLK),
    .i_rst       (i_rst),
    .i_start     (start),
    .i_imgLength (imgLength),
    .o_done      (done),
    .run         (runBus.seq),
    .eng         (engBus.src)
  );

  convEngine engine0 (
    .i_CLK     (i_CLK),
    .i_rst     (i_rst),
    .i_kerWrEn (kerWrEn),
    .i_kerRow  (kerRow),
    .eng       (engBus.eng)
  );

endmodule

`default_nettype wire
